// ==== include/nco_consts.svh ====
`ifndef NCO_CONSTS_SVH
`define NCO_CONSTS_SVH

// period word, fixed point.
`define NCO_DATA_W 32
`define NCO_FRAC_W 8   // fractional bits of the period.

// completed period counter.
`define NCO_NPER_W 32

`define NCO_ADDR_W 2

// register map.
`define NCO_ADDR_ENABLE     2'd0
`define NCO_ADDR_SOFT_RESET 2'd1
`define NCO_ADDR_PERIOD     2'd2
`define NCO_ADDR_NPER       2'd3   // read only.

`define NCO_MIN_QUANT 2   // shortest whole period giving a clock.

`endif

// ==== logic/nco_core.sv ====
`timescale 1ns/1ps
`include "nco_consts.svh"

module nco_core (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  enable_i,
  input  logic                  soft_reset_i,
  input  logic                  period_wen_i,
  input  nco_data_pkg::period_t period_wdata_i,
  output nco_data_pkg::period_t period_r_o,
  output nco_data_pkg::nper_t   nper_o,
  output logic                  clk_o
);

  nco_data_pkg::period_t   period_r;   // programmed period.
  nco_data_pkg::period_t   acc_r;      // period plus carried error.
  nco_data_pkg::period_t   diff;
  nco_data_pkg::quant_t    acc_int;
  nco_data_pkg::quant_t    quant;
  nco_data_pkg::quant_t    cnt_r;
  nco_data_pkg::nper_t     nper_r;
  logic [`NCO_FRAC_W-1:0]  acc_frac;
  logic                    quant_ok;
  logic                    wrap;
  logic                    clk_nxt;
  logic                    clk_r;

  assign acc_int  = acc_r[`NCO_DATA_W-1:`NCO_FRAC_W];
  assign acc_frac = acc_r[`NCO_FRAC_W-1:0];

  // round to nearest, ties go by parity of the integer part.
  always_comb begin
    if (acc_frac == {1'b1, {(`NCO_FRAC_W-1){1'b0}}}) begin
      quant = acc_int + nco_data_pkg::quant_t'(^acc_int);
    end else if (acc_frac[`NCO_FRAC_W-1]) begin
      quant = acc_int + nco_data_pkg::quant_t'(1);
    end else begin
      quant = acc_int;
    end
  end

  // error left over by the period just emitted.
  assign diff = period_r - {quant, {`NCO_FRAC_W{1'b0}}};

  assign quant_ok = (quant >= nco_data_pkg::quant_t'(`NCO_MIN_QUANT));
  assign wrap     = enable_i && quant_ok && (cnt_r == quant - nco_data_pkg::quant_t'(1));

  // high for the upper part of each period.
  assign clk_nxt = quant_ok && (cnt_r > (quant >> 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      period_r <= '0;
    end else if (soft_reset_i) begin
      period_r <= '0;
    end else if (period_wen_i) begin
      period_r <= period_wdata_i;
    end
  end

  // error accumulator, reloaded on a period write.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_r <= '0;
    end else if (soft_reset_i) begin
      acc_r <= '0;
    end else if (period_wen_i) begin
      acc_r <= period_wdata_i;
    end else if (wrap) begin
      acc_r <= acc_r + diff;
    end
  end

  // modulo-quant period counter.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_r <= '0;
    end else if (soft_reset_i || period_wen_i) begin
      cnt_r <= '0;
    end else if (enable_i) begin
      if (!quant_ok || wrap) begin
        cnt_r <= '0;   // held at zero when the period is too short.
      end else begin
        cnt_r <= cnt_r + nco_data_pkg::quant_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nper_r <= '0;
    end else if (soft_reset_i) begin
      nper_r <= '0;
    end else if (wrap) begin
      nper_r <= nper_r + nco_data_pkg::nper_t'(1);   // one per completed period.
    end
  end

  // output clock, one cycle behind the counter.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_r <= 1'b0;
    end else if (soft_reset_i) begin
      clk_r <= 1'b0;
    end else if (enable_i) begin
      clk_r <= clk_nxt;
    end
  end

  assign period_r_o = period_r;
  assign nper_o     = nper_r;
  assign clk_o      = clk_r;

endmodule

// ==== logic/nco_csr_pkg.sv ====
`include "nco_consts.svh"

package nco_csr_pkg;

  // register address on the request bus.
  typedef logic [`NCO_ADDR_W-1:0] csr_addr_t;

  // data word on both buses.
  typedef logic [`NCO_DATA_W-1:0] csr_data_t;

  // read response tracking.
  typedef enum logic {
    RSP_IDLE = 1'b0,  // no response owed.
    RSP_PEND = 1'b1   // read data waiting for rsp_ready_i.
  } rsp_state_t;

endpackage

// ==== logic/nco_csr_regs.sv ====
`timescale 1ns/1ps
`include "nco_consts.svh"

module nco_csr_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // request bus.
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  nco_csr_pkg::csr_addr_t req_addr_i,
  input  nco_csr_pkg::csr_data_t req_wdata_i,
  // response bus.
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output nco_csr_pkg::csr_data_t rsp_rdata_o,
  // core control.
  output logic                   enable_o,
  output logic                   soft_reset_o,
  output logic                   period_wen_o,
  output nco_data_pkg::period_t  period_wdata_o,
  input  nco_data_pkg::period_t  period_r_i,
  input  nco_data_pkg::nper_t    nper_i
);

  nco_csr_pkg::rsp_state_t rsp_state;
  nco_csr_pkg::csr_data_t  rd_data;
  nco_csr_pkg::csr_data_t  rsp_rdata_r;
  logic                    enable_r;
  logic                    req_acc;
  logic                    wr_acc;
  logic                    rd_acc;

  // stall only while a read response is owed.
  assign req_ready_o = (rsp_state == nco_csr_pkg::RSP_IDLE);
  assign req_acc     = req_valid_i && req_ready_o;
  assign wr_acc      = req_acc && req_we_i;
  assign rd_acc      = req_acc && !req_we_i;

  // one-cycle strobes, the core acts on the accepting edge.
  assign soft_reset_o   = wr_acc && (req_addr_i == `NCO_ADDR_SOFT_RESET);
  assign period_wen_o   = wr_acc && (req_addr_i == `NCO_ADDR_PERIOD);
  assign period_wdata_o = nco_data_pkg::period_t'(req_wdata_i);

  assign enable_o    = enable_r;
  assign rsp_valid_o = (rsp_state == nco_csr_pkg::RSP_PEND);
  assign rsp_rdata_o = rsp_rdata_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_r <= 1'b0;
    end else if (soft_reset_o) begin
      enable_r <= 1'b0;   // soft reset drops enable too.
    end else if (wr_acc && (req_addr_i == `NCO_ADDR_ENABLE)) begin
      enable_r <= req_wdata_i[0];
    end
  end

  // read mux.
  always_comb begin
    case (req_addr_i)
      `NCO_ADDR_ENABLE: rd_data = nco_csr_pkg::csr_data_t'(enable_r);
      `NCO_ADDR_PERIOD: rd_data = nco_csr_pkg::csr_data_t'(period_r_i);
      `NCO_ADDR_NPER:   rd_data = nco_csr_pkg::csr_data_t'(nper_i);
      default:          rd_data = '0;   // soft reset reads as zero.
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_state <= nco_csr_pkg::RSP_IDLE;
    end else begin
      case (rsp_state)
        nco_csr_pkg::RSP_IDLE: if (rd_acc) rsp_state <= nco_csr_pkg::RSP_PEND;
        nco_csr_pkg::RSP_PEND: if (rsp_ready_i) rsp_state <= nco_csr_pkg::RSP_IDLE;
        default:               rsp_state <= nco_csr_pkg::RSP_IDLE;
      endcase
    end
  end

  // held until the master takes it.
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rsp_rdata_r <= rd_data;
    end
  end

endmodule

// ==== logic/nco_data_pkg.sv ====
`include "nco_consts.svh"

package nco_data_pkg;

  // fixed-point period, also the error accumulator.
  typedef logic [`NCO_DATA_W-1:0] period_t;

  // whole cycles, integer part of a period.
  typedef logic [`NCO_DATA_W-`NCO_FRAC_W-1:0] quant_t;

  typedef logic [`NCO_NPER_W-1:0] nper_t;   // completed output periods.

endpackage

// ==== logic/nco_top.sv ====
`timescale 1ns/1ps
`include "nco_consts.svh"

module nco_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  nco_csr_pkg::csr_addr_t req_addr_i,
  input  nco_csr_pkg::csr_data_t req_wdata_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output nco_csr_pkg::csr_data_t rsp_rdata_o,
  output logic                   clk_o
);

  logic                  enable;
  logic                  soft_reset;   // single-cycle strobe.
  logic                  period_wen;
  nco_data_pkg::period_t period_wdata;
  nco_data_pkg::period_t period_r;
  nco_data_pkg::nper_t   nper;

  nco_csr_regs u_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_we_i       (req_we_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_rdata_o    (rsp_rdata_o),
    .enable_o       (enable),
    .soft_reset_o   (soft_reset),
    .period_wen_o   (period_wen),
    .period_wdata_o (period_wdata),
    .period_r_i     (period_r),
    .nper_i         (nper)
  );

  // oscillator datapath.
  nco_core u_core (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .enable_i       (enable),
    .soft_reset_i   (soft_reset),
    .period_wen_i   (period_wen),
    .period_wdata_i (period_wdata),
    .period_r_o     (period_r),
    .nper_o         (nper),
    .clk_o          (clk_o)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the NCO testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module nco_tb -o nco_sim

./obj_dir/nco_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "no final status in sim.log"
  exit 1
fi
exit 0

// ==== sources.f ====
+incdir+include
logic/nco_csr_pkg.sv
logic/nco_data_pkg.sv
logic/nco_csr_regs.sv
logic/nco_core.sv
logic/nco_top.sv
verification/nco_clk_gen.sv
verification/nco_asserts.sv
verification/nco_tb.sv

// ==== verification/nco_asserts.sv ====
`timescale 1ns/1ps
`include "nco_consts.svh"

module nco_asserts (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   req_valid_i,
  input logic                   req_we_i,
  input nco_csr_pkg::csr_addr_t req_addr_i,
  input logic                   req_ready_o,
  input logic                   rsp_valid_o,
  input logic                   rsp_ready_i,
  input nco_csr_pkg::csr_data_t rsp_rdata_o,
  input logic                   clk_o
);

  int   fail_cnt;
  logic rd_owed;    // read accepted, response not yet taken.
  logic soft_acc;

  initial fail_cnt = 0;

  assign soft_acc = req_valid_i && req_ready_o && req_we_i &&
                    (req_addr_i == `NCO_ADDR_SOFT_RESET);

  // bus-side view of an outstanding read.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_owed <= 1'b0;
    end else if (req_valid_i && req_ready_o && !req_we_i) begin
      rd_owed <= 1'b1;
    end else if (rsp_valid_o && rsp_ready_i) begin
      rd_owed <= 1'b0;
    end
  end

  // no new request while a read response is owed.
  ready_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_owed |-> !req_ready_o)
  else begin
    $error("req_ready_o high while a read response is pending");
    fail_cnt++;
  end

  // response held until taken.
  rsp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o))
  else begin
    $error("read response dropped or rsp_rdata_o changed while stalled");
    fail_cnt++;
  end

  rsp_follows_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_o && !req_we_i |=> rsp_valid_o)
  else begin
    $error("no response on the cycle after an accepted read");
    fail_cnt++;
  end

  // soft reset forces the output clock low.
  soft_clears_clk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    soft_acc |=> !clk_o)
  else begin
    $error("clk_o high after a soft reset");
    fail_cnt++;
  end

endmodule

// ==== verification/nco_clk_gen.sv ====
`timescale 1ns/1ps

module nco_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;   // 10 ns period.
  end

  // reset held low for 8 cycles.
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== verification/nco_tb.sv ====
`timescale 1ns/1ps
`include "nco_consts.svh"

module nco_tb;

  // window lengths in cycles, for the watchdog.
  localparam int T3_CYCLES = 20 * 18 + 40;
  localparam int T4_CYCLES = 18 * 11 + 40;
  localparam int T5_CYCLES = 300;
  localparam int BUS_CYCLES = 40 * 8;   // reads and writes with stalls.
  localparam int WD_CYCLES = T3_CYCLES + T4_CYCLES + T5_CYCLES + BUS_CYCLES + 1000;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  logic                   req_ready;
  logic                   req_we;
  nco_csr_pkg::csr_addr_t req_addr;
  nco_csr_pkg::csr_data_t req_wdata;
  logic                   rsp_valid;
  logic                   rsp_ready;
  nco_csr_pkg::csr_data_t rsp_rdata;
  logic                   clk_out;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_start_errs;
  logic [31:0] lfsr_state;
  int          gaps[$];

  nco_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  nco_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_rdata_o (rsp_rdata),
    .clk_o       (clk_out)
  );

  bind nco_top nco_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .clk_o       (clk_o)
  );

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic int total_errors();
    return errors + u_dut.u_asserts.fail_cnt;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic bus_write(input nco_csr_pkg::csr_addr_t addr,
                           input nco_csr_pkg::csr_data_t data);
    @(posedge clk);
    req_valid <= 1'b1;
    req_we    <= 1'b1;
    req_addr  <= addr;
    req_wdata <= data;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);   // accepting edge.
    req_valid <= 1'b0;
    req_we    <= 1'b0;
  endtask

  task automatic bus_read(input nco_csr_pkg::csr_addr_t addr,
                          output nco_csr_pkg::csr_data_t data);
    int stall;
    int wait_cyc;
    stall    = int'(rand_bits(2));
    wait_cyc = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_we    <= 1'b0;
    req_addr  <= addr;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
    do begin
      @(negedge clk);
      wait_cyc++;
    end while (!rsp_valid && wait_cyc < 20);
    check_true(rsp_valid, "no read response within 20 cycles");
    data = rsp_rdata;
    repeat (stall) @(posedge clk);   // random back-pressure.
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(posedge clk);
    rsp_ready <= 1'b0;
  endtask

  task automatic read_check(input nco_csr_pkg::csr_addr_t addr,
                            input logic [31:0] exp, input string name);
    nco_csr_pkg::csr_data_t got;
    bus_read(addr, got);
    check_value(name, got, exp);
  endtask

  // collects gaps between rising edges of clk_o, sampled mid-cycle.
  task automatic measure_edges(input int num_edges, input int max_gap);
    logic prev;
    int   cyc;
    int   seen;
    gaps.delete();
    cyc  = 0;
    seen = 0;
    @(negedge clk);
    prev = clk_out;
    while (seen < num_edges) begin
      @(negedge clk);
      cyc++;
      if (clk_out && !prev) begin
        if (seen > 0) gaps.push_back(cyc);
        cyc = 0;
        seen++;
      end
      prev = clk_out;
      if (cyc > max_gap) begin
        $display("Error: no rising edge on clk_o within %0d cycles", max_gap);
        errors++;
        break;
      end
    end
  endtask

  task automatic hold_check(input int cycles, input logic exp, input string what);
    repeat (cycles) begin
      @(negedge clk);
      check_true(clk_out === exp, what);
    end
  endtask

  task automatic start_test();
    test_start_errs = total_errors();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() > test_start_errs) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  initial begin
    #(WD_CYCLES * 10);
    $display("Error: watchdog expired after %0d cycles", WD_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    nco_csr_pkg::csr_data_t n0;
    nco_csr_pkg::csr_data_t n1;
    logic [31:0] val;
    int          per_int;
    int          frac;
    int          per;
    longint      sum;
    longint      dev;
    logic        frozen;

    req_valid  = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    rsp_ready  = 1'b0;
    lfsr_state = 32'd32;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;

    @(posedge rst_n);
    @(negedge clk);

    start_test();
    check_value("clk_o", {31'd0, clk_out}, 32'd0);
    check_value("rsp_valid_o", {31'd0, rsp_valid}, 32'd0);
    check_value("req_ready_o", {31'd0, req_ready}, 32'd1);
    read_check(`NCO_ADDR_ENABLE, 32'd0, "enable");
    read_check(`NCO_ADDR_PERIOD, 32'd0, "period");
    read_check(`NCO_ADDR_NPER, 32'd0, "nper");
    end_test("reset_state");

    start_test();
    for (int i = 0; i < 4; i++) begin
      val = rand_bits(32);
      bus_write(`NCO_ADDR_PERIOD, val);
      read_check(`NCO_ADDR_PERIOD, val, "period");
      val = rand_bits(1);
      bus_write(`NCO_ADDR_ENABLE, val);
      read_check(`NCO_ADDR_ENABLE, val, "enable");
    end
    bus_write(`NCO_ADDR_PERIOD, 32'd0);
    end_test("register_access");

    // whole period, 20 periods between the period write and the disable.
    start_test();
    per_int = 3 + int'(rand_bits(4));
    bus_write(`NCO_ADDR_ENABLE, 32'd1);
    bus_read(`NCO_ADDR_NPER, n0);
    bus_write(`NCO_ADDR_PERIOD, per_int << `NCO_FRAC_W);
    fork
      measure_edges(20, 3 * per_int);
      begin
        repeat (20 * per_int - 2) @(posedge clk);
        bus_write(`NCO_ADDR_ENABLE, 32'd0);
      end
    join
    check_value("edge_count", gaps.size(), 32'd19);
    foreach (gaps[i]) check_value("clk_o spacing", gaps[i], per_int);
    bus_read(`NCO_ADDR_NPER, n1);
    check_value("nper delta", n1 - n0, 32'd20);
    end_test("integer_period");

    // even integer part keeps the high phase start fixed.
    start_test();
    per_int = 4 + 2 * int'(rand_bits(2));
    frac    = int'(rand_bits(8)) | 1;
    per     = (per_int << `NCO_FRAC_W) | frac;
    bus_write(`NCO_ADDR_PERIOD, per);
    bus_write(`NCO_ADDR_ENABLE, 32'd1);
    measure_edges(17, 2 * per_int + 4);
    check_value("edge_count", gaps.size(), 32'd16);
    sum = 0;
    foreach (gaps[i]) begin
      check_true(gaps[i] == per_int || gaps[i] == per_int + 1,
                 "clk_o spacing is neither floor nor ceiling of the period");
      sum += gaps[i];
    end
    dev = (sum << `NCO_FRAC_W) - longint'(16) * per;
    check_true(dev > -256 && dev < 256, "16 spacings drift a cycle or more from the period");
    bus_write(`NCO_ADDR_ENABLE, 32'd0);
    end_test("fractional_period");

    start_test();
    bus_write(`NCO_ADDR_PERIOD, 32'd6 << `NCO_FRAC_W);
    bus_write(`NCO_ADDR_ENABLE, 32'd1);
    measure_edges(2, 16);
    bus_write(`NCO_ADDR_ENABLE, 32'd0);
    @(negedge clk);
    frozen = clk_out;
    bus_read(`NCO_ADDR_NPER, n0);
    hold_check(30, frozen, "clk_o moved with enable low");
    bus_read(`NCO_ADDR_NPER, n1);
    check_value("nper frozen", n1, n0);
    bus_write(`NCO_ADDR_ENABLE, 32'd1);
    measure_edges(1, 16);
    repeat (4) @(posedge clk);   // soft reset lands where clk_o would rise.
    bus_write(`NCO_ADDR_SOFT_RESET, 32'h5a);
    hold_check(20, 1'b0, "clk_o high after soft reset");
    read_check(`NCO_ADDR_PERIOD, 32'd0, "period");
    read_check(`NCO_ADDR_ENABLE, 32'd0, "enable");
    read_check(`NCO_ADDR_NPER, 32'd0, "nper");
    bus_write(`NCO_ADDR_PERIOD, 32'h120);   // 1.125 rounds to 1.
    bus_write(`NCO_ADDR_ENABLE, 32'd1);
    hold_check(40, 1'b0, "clk_o toggled with a period below the minimum");
    read_check(`NCO_ADDR_NPER, 32'd0, "nper");
    bus_write(`NCO_ADDR_PERIOD, 32'h20);    // 0.125 rounds to 0.
    hold_check(40, 1'b0, "clk_o toggled with a period below the minimum");
    bus_write(`NCO_ADDR_ENABLE, 32'd0);
    end_test("control");

    $display("tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, u_dut.u_asserts.fail_cnt);
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
